/* list.f */
+incdir+source
source/fc_pkg.sv
source/wb_if.sv
source/wb_decoder.sv
source/led_regs.sv
source/motor_select.sv
source/dshot_ctrl.sv
source/flight_io_top.sv
testbench/flight_io_tb.sv

/* source/dshot_ctrl.sv */
// Four-channel DSHOT600 transmitter

`timescale 1ns/10ps
`include "fc_defines.svh"

module dshot_ctrl (
    input  logic               i_sys_clk,
    input  logic               reset_i,
    wb_if.slave                bus,
    output fc_pkg::motor_vec_t dshot_line_o
);
    import fc_pkg::*;

    localparam int TIMER_MAX = (`FC_DSHOT_BIT_CLKS > `FC_DSHOT_GAP_CLKS) ?
                               `FC_DSHOT_BIT_CLKS : `FC_DSHOT_GAP_CLKS;
    localparam int TIMER_W   = $clog2(TIMER_MAX);

    localparam logic [TIMER_W-1:0] BIT_LAST = TIMER_W'(`FC_DSHOT_BIT_CLKS - 1);
    localparam logic [TIMER_W-1:0] GAP_LAST = TIMER_W'(`FC_DSHOT_GAP_CLKS - 1);
    localparam logic [TIMER_W-1:0] T1H      = TIMER_W'(`FC_DSHOT_T1H_CLKS);
    localparam logic [TIMER_W-1:0] T0H      = TIMER_W'(`FC_DSHOT_T0H_CLKS);

    logic [11:0]        thr_q [`FC_MOTOR_COUNT];
    dshot_frame_u       sh_q  [`FC_MOTOR_COUNT];
    logic [TIMER_W-1:0] timer_q;
    logic [3:0]         bit_cnt_q;
    logic               busy_q;
    logic               sending_q;
    motor_vec_t         line_q;
    logic               ack_q;
    logic               access;
    logic               wr;
    logic               is_thr;
    logic               trigger;
    logic               bit_end;
    logic [7:0]         offset;

    // Checksum over the three nibbles of throttle and telemetry
    function automatic dshot_frame_u build_frame(input logic [11:0] word);
        dshot_frame_u f;
        f.fields.throttle = word[11:1];
        f.fields.telem    = word[0];
        f.fields.crc      = f.raw[15:12] ^ f.raw[11:8] ^ f.raw[7:4];
        return f;
    endfunction

    // ========================================================================
    // Register access
    // ========================================================================
    assign offset  = bus.adr[7:0];
    assign access  = bus.stb & bus.cyc & ~ack_q;
    assign wr      = access & bus.we;
    assign is_thr  = (offset[7:4] == 4'h0) && (offset[1:0] == 2'b00);
    assign trigger = wr & (offset == 8'h10) & bus.dat_w[0] & ~busy_q;

    always_ff @(posedge i_sys_clk) begin
        if (wr && is_thr) begin
            thr_q[offset[3:2]] <= bus.dat_w[11:0];
        end
    end

    always_comb begin
        if (offset == 8'h10) begin
            bus.dat_r = wb_data_t'(busy_q);
        end else if (is_thr) begin
            bus.dat_r = wb_data_t'(thr_q[offset[3:2]]);
        end else begin
            bus.dat_r = '0;
        end
    end

    assign bus.ack = ack_q;

    // ========================================================================
    // Bit sequencer shared by all channels
    // ========================================================================
    assign bit_end = sending_q && (timer_q == BIT_LAST);

    always_ff @(posedge i_sys_clk) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            busy_q    <= 1'b0;
            sending_q <= 1'b0;
            timer_q   <= '0;
            bit_cnt_q <= '0;
        end else begin
            ack_q <= access;
            if (trigger) begin
                busy_q    <= 1'b1;
                sending_q <= 1'b1;
                timer_q   <= '0;
                bit_cnt_q <= '0;
            end else if (sending_q) begin
                if (bit_end) begin
                    timer_q   <= '0;
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                    // Sixteenth bit done, start the gap
                    if (bit_cnt_q == 4'd15) begin
                        sending_q <= 1'b0;
                    end
                end else begin
                    timer_q <= timer_q + 1'b1;
                end
            end else if (busy_q) begin
                if (timer_q == GAP_LAST) begin
                    busy_q  <= 1'b0;
                    timer_q <= '0;
                end else begin
                    timer_q <= timer_q + 1'b1;
                end
            end
        end
    end

    // Frames are latched at the trigger and shifted MSB first
    always_ff @(posedge i_sys_clk) begin
        for (int i = 0; i < `FC_MOTOR_COUNT; i++) begin
            if (trigger) begin
                sh_q[i] <= build_frame(thr_q[i]);
            end else if (bit_end) begin
                sh_q[i].raw <= {sh_q[i].raw[14:0], 1'b0};
            end
        end
    end

    // Registered pads, high for T1H or T0H at the start of each bit
    always_ff @(posedge i_sys_clk) begin
        if (reset_i) begin
            line_q <= '0;
        end else begin
            for (int i = 0; i < `FC_MOTOR_COUNT; i++) begin
                line_q[i] <= sending_q && (sh_q[i].raw[15] ? (timer_q < T1H) : (timer_q < T0H));
            end
        end
    end

    assign dshot_line_o = line_q;

    a_idle_low: assert property (@(posedge i_sys_clk) disable iff (reset_i)
        !busy_q |-> (dshot_line_o == '0));

endmodule

/* source/fc_defines.svh */
// Flight I/O core build constants

`ifndef FC_DEFINES_SVH
`define FC_DEFINES_SVH

// Bus widths
`define FC_WB_ADDR_W      16
`define FC_WB_DATA_W      32

// Address map, one 256-byte page per slave
`define FC_LED_BASE       16'h0000
`define FC_DSHOT_BASE     16'h0300
`define FC_MSEL_BASE      16'h0400
`define FC_SLAVE_MASK     16'hFF00

// LEDs are wired to sink current
`define FC_LED_COUNT      5
`define FC_LED_ACTIVE_LOW 1

`define FC_MOTOR_COUNT    4

// DSHOT600 timing in 72 MHz clocks
`define FC_DSHOT_BIT_CLKS 120
`define FC_DSHOT_T1H_CLKS 90
`define FC_DSHOT_T0H_CLKS 45
`define FC_DSHOT_GAP_CLKS 240

`endif

/* source/fc_pkg.sv */
// Flight I/O core shared types

`include "fc_defines.svh"

package fc_pkg;

    typedef logic [`FC_WB_ADDR_W-1:0]   wb_addr_t;
    typedef logic [`FC_WB_DATA_W-1:0]   wb_data_t;
    typedef logic [`FC_LED_COUNT-1:0]   led_vec_t;
    typedef logic [`FC_MOTOR_COUNT-1:0] motor_vec_t;
    typedef logic [$clog2(`FC_MOTOR_COUNT)-1:0] motor_ch_t;

    // Field view of a DSHOT frame, MSB sent first
    typedef struct packed {
        logic [10:0] throttle;
        logic        telem;
        logic [3:0]  crc;
    } dshot_fields_t;

    // Same 16 bits seen as the serial word or as fields
    typedef union packed {
        logic [15:0]   raw;
        dshot_fields_t fields;
    } dshot_frame_u;

endpackage

/* source/flight_io_top.sv */
// Flight controller motor and LED I/O

`timescale 1ns/10ps

module flight_io_top (
    input  logic               i_sys_clk,
    input  logic               reset_i,
    input  fc_pkg::wb_addr_t   wb_adr_i,
    input  fc_pkg::wb_data_t   wb_dat_i,
    input  logic               wb_we_i,
    input  logic               wb_stb_i,
    input  logic               wb_cyc_i,
    input  logic               usb_uart_rx_i,
    input  fc_pkg::motor_vec_t motor_fb_i,
    output fc_pkg::wb_data_t   wb_dat_o,
    output logic               wb_ack_o,
    output logic               wb_err_o,
    output fc_pkg::led_vec_t   led_o,
    output logic               usb_uart_tx_o,
    output fc_pkg::motor_vec_t motor_o
);
    import fc_pkg::*;

    // DSHOT pad drive before the select
    motor_vec_t dshot_line;

    wb_if bus_led ();
    wb_if bus_dshot ();
    wb_if bus_msel ();

    // ========================================================================
    // Bus decode
    // ========================================================================
    wb_decoder u_decoder (
        .i_sys_clk (i_sys_clk),
        .reset_i   (reset_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_we_i   (wb_we_i),
        .wb_stb_i  (wb_stb_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .led_bus   (bus_led.master),
        .dshot_bus (bus_dshot.master),
        .msel_bus  (bus_msel.master)
    );

    // ========================================================================
    // Peripherals
    // ========================================================================
    led_regs u_led (
        .i_sys_clk (i_sys_clk),
        .reset_i   (reset_i),
        .bus       (bus_led.slave),
        .led_o     (led_o)
    );

    dshot_ctrl u_dshot (
        .i_sys_clk    (i_sys_clk),
        .reset_i      (reset_i),
        .bus          (bus_dshot.slave),
        .dshot_line_o (dshot_line)
    );

    motor_select u_msel (
        .i_sys_clk     (i_sys_clk),
        .reset_i       (reset_i),
        .bus           (bus_msel.slave),
        .dshot_line_i  (dshot_line),
        .usb_uart_rx_i (usb_uart_rx_i),
        .motor_fb_i    (motor_fb_i),
        .motor_o       (motor_o),
        .usb_uart_tx_o (usb_uart_tx_o)
    );

endmodule

/* source/led_regs.sv */
// Status LED register

`timescale 1ns/10ps
`include "fc_defines.svh"

module led_regs (
    input  logic             i_sys_clk,
    input  logic             reset_i,
    wb_if.slave              bus,
    output fc_pkg::led_vec_t led_o
);
    import fc_pkg::*;

    led_vec_t led_q;
    logic     ack_q;
    logic     access;

    // First cycle of a request only
    assign access = bus.stb & bus.cyc & ~ack_q;

    always_ff @(posedge i_sys_clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            led_q <= '0;
        end else begin
            ack_q <= access;
            if (access && bus.we && (bus.adr[7:0] == 8'h00)) begin
                led_q <= bus.dat_w[`FC_LED_COUNT-1:0];
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = wb_data_t'(led_q);

    // A set bit means LED on
    generate
        if (`FC_LED_ACTIVE_LOW != 0) begin : g_sink
            assign led_o = ~led_q;
        end else begin : g_source
            assign led_o = led_q;
        end
    endgenerate

endmodule

/* source/motor_select.sv */
// Motor pad select for DSHOT or UART passthrough

`timescale 1ns/10ps

module motor_select (
    input  logic               i_sys_clk,
    input  logic               reset_i,
    wb_if.slave                bus,
    input  fc_pkg::motor_vec_t dshot_line_i,
    input  logic               usb_uart_rx_i,
    input  fc_pkg::motor_vec_t motor_fb_i,
    output fc_pkg::motor_vec_t motor_o,
    output logic               usb_uart_tx_o
);
    import fc_pkg::*;

    logic      mode_q;
    motor_ch_t ch_q;
    logic      ack_q;
    logic      access;

    assign access = bus.stb & bus.cyc & ~ack_q;

    // ========================================================================
    // Mode and channel register
    // ========================================================================
    always_ff @(posedge i_sys_clk) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            mode_q <= 1'b0;
            ch_q   <= '0;
        end else begin
            ack_q <= access;
            if (access && bus.we && (bus.adr[7:0] == 8'h00)) begin
                mode_q <= bus.dat_w[0];
                ch_q   <= bus.dat_w[2:1];
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = wb_data_t'({ch_q, mode_q});

    // ========================================================================
    // Pad routing
    // ========================================================================
    always_comb begin
        if (mode_q) begin
            motor_o       = dshot_line_i;
            usb_uart_tx_o = 1'b1;
        end else begin
            // Unused pads idle high like a UART line
            motor_o       = '1;
            motor_o[ch_q] = usb_uart_rx_i;
            usb_uart_tx_o = motor_fb_i[ch_q];
        end
    end

endmodule

/* source/wb_decoder.sv */
// Wishbone address decoder and response mux

`timescale 1ns/10ps
`include "fc_defines.svh"

module wb_decoder (
    input  logic             i_sys_clk,
    input  logic             reset_i,
    input  fc_pkg::wb_addr_t wb_adr_i,
    input  fc_pkg::wb_data_t wb_dat_i,
    input  logic             wb_we_i,
    input  logic             wb_stb_i,
    input  logic             wb_cyc_i,
    output fc_pkg::wb_data_t wb_dat_o,
    output logic             wb_ack_o,
    output logic             wb_err_o,
    wb_if.master             led_bus,
    wb_if.master             dshot_bus,
    wb_if.master             msel_bus
);

    logic sel_led;
    logic sel_dshot;
    logic sel_msel;
    logic req;
    logic err_q;

    assign req = wb_stb_i & wb_cyc_i;

    // Page match on the upper address byte
    assign sel_led   = ((wb_adr_i & `FC_SLAVE_MASK) == `FC_LED_BASE);
    assign sel_dshot = ((wb_adr_i & `FC_SLAVE_MASK) == `FC_DSHOT_BASE);
    assign sel_msel  = ((wb_adr_i & `FC_SLAVE_MASK) == `FC_MSEL_BASE);

    // ========================================================================
    // Request fan-out
    // ========================================================================
    assign led_bus.adr   = wb_adr_i;
    assign led_bus.dat_w = wb_dat_i;
    assign led_bus.we    = wb_we_i;
    assign led_bus.stb   = wb_stb_i & sel_led;
    assign led_bus.cyc   = wb_cyc_i & sel_led;

    assign dshot_bus.adr   = wb_adr_i;
    assign dshot_bus.dat_w = wb_dat_i;
    assign dshot_bus.we    = wb_we_i;
    assign dshot_bus.stb   = wb_stb_i & sel_dshot;
    assign dshot_bus.cyc   = wb_cyc_i & sel_dshot;

    assign msel_bus.adr   = wb_adr_i;
    assign msel_bus.dat_w = wb_dat_i;
    assign msel_bus.we    = wb_we_i;
    assign msel_bus.stb   = wb_stb_i & sel_msel;
    assign msel_bus.cyc   = wb_cyc_i & sel_msel;

    // ========================================================================
    // Response path
    // ========================================================================
    always_comb begin
        wb_dat_o = '0;
        if (sel_led) begin
            wb_dat_o = led_bus.dat_r;
        end else if (sel_dshot) begin
            wb_dat_o = dshot_bus.dat_r;
        end else if (sel_msel) begin
            wb_dat_o = msel_bus.dat_r;
        end
    end

    assign wb_ack_o = (sel_led & led_bus.ack) | (sel_dshot & dshot_bus.ack)
                    | (sel_msel & msel_bus.ack);

    // Unmapped page gets a one-cycle error pulse
    always_ff @(posedge i_sys_clk) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & ~(sel_led | sel_dshot | sel_msel) & ~err_q;
        end
    end

    assign wb_err_o = err_q;

    a_ack_err_excl: assert property (@(posedge i_sys_clk) disable iff (reset_i)
        !(wb_ack_o && wb_err_o));

endmodule

/* source/wb_if.sv */
// Wishbone link to one peripheral

`timescale 1ns/10ps

interface wb_if;
    import fc_pkg::*;

    wb_addr_t adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     we;
    logic     stb;
    logic     cyc;
    logic     ack;

    // Decoder side
    modport master (output adr, dat_w, we, stb, cyc, input dat_r, ack);

    // Peripheral side
    modport slave (input adr, dat_w, we, stb, cyc, output dat_r, ack);

endinterface

/* testbench/flight_io_tb.sv */
// Flight I/O core directed testbench

`timescale 1ns/10ps
`include "fc_defines.svh"

module flight_io_tb;
    import fc_pkg::*;

    localparam int       TIMEOUT_CYCLES = 20000;
    localparam int       BIT_CLKS       = `FC_DSHOT_BIT_CLKS;
    localparam int       FRAME_CLKS     = 16 * `FC_DSHOT_BIT_CLKS;
    localparam int       MID_HIGH       = (`FC_DSHOT_T0H_CLKS + `FC_DSHOT_T1H_CLKS) / 2;
    localparam wb_addr_t CTRL_ADR       = `FC_DSHOT_BASE + 16'h0010;

    logic         i_sys_clk;
    logic         reset_i;
    wb_addr_t     wb_adr_i;
    wb_data_t     wb_dat_i;
    logic         wb_we_i;
    logic         wb_stb_i;
    logic         wb_cyc_i;
    logic         usb_uart_rx_i;
    motor_vec_t   motor_fb_i;
    wb_data_t     wb_dat_o;
    logic         wb_ack_o;
    logic         wb_err_o;
    led_vec_t     led_o;
    logic         usb_uart_tx_o;
    motor_vec_t   motor_o;
    dshot_frame_u meas_frame [`FC_MOTOR_COUNT];
    logic         busy_done;
    int           cycle_cnt = 0;

    flight_io_top UUT (.*);

    always #4 i_sys_clk = ~i_sys_clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    always @(posedge i_sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout, run still going after %0d cycles", cycle_cnt));
        end
    end

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_word(input wb_data_t got, input wb_data_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_frame(input dshot_frame_u got, input dshot_frame_u exp,
                               input string name);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_motor(input motor_vec_t got, input motor_vec_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_led(input led_vec_t got, input led_vec_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Frame word from the throttle word, CRC over the three upper nibbles
    function automatic dshot_frame_u expected_frame(input logic [11:0] word);
        dshot_frame_u f;
        f.raw = {word, word[11:8] ^ word[7:4] ^ word[3:0]};
        return f;
    endfunction

    // ========================================================================
    // Bus host
    // ========================================================================
    task automatic bus_access(input wb_addr_t adr, input wb_data_t dat, input logic we,
                              output wb_data_t rdat);
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_we_i  = we;
        wb_stb_i = 1'b1;
        wb_cyc_i = 1'b1;
        @(posedge i_sys_clk);
        @(negedge i_sys_clk);
        if (wb_ack_o !== 1'b1 || wb_err_o !== 1'b0) begin
            fail_run($sformatf("No ack one cycle after the access to address 0x%h", adr));
        end
        rdat     = wb_dat_o;
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_we_i  = 1'b0;
        // Idle cycle between accesses
        @(negedge i_sys_clk);
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_access(adr, dat, 1'b1, unused);
    endtask

    task automatic bus_read(input wb_addr_t adr, output wb_data_t rdat);
        bus_access(adr, '0, 1'b0, rdat);
    endtask

    task automatic bus_expect_err(input wb_addr_t adr);
        wb_adr_i = adr;
        wb_we_i  = 1'b0;
        wb_stb_i = 1'b1;
        wb_cyc_i = 1'b1;
        @(posedge i_sys_clk);
        @(negedge i_sys_clk);
        check_bit(wb_err_o, 1'b1, "wb_err_o");
        check_bit(wb_ack_o, 1'b0, "wb_ack_o");
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        @(negedge i_sys_clk);
        check_bit(wb_err_o, 1'b0, "wb_err_o");
    endtask

    // ========================================================================
    // DSHOT helpers
    // ========================================================================
    task automatic wait_frame_start();
        int n;
        n = 0;
        while (motor_o == '0) begin
            n++;
            if (n > 8) begin
                fail_run("No DSHOT frame started after the trigger write");
            end
            @(negedge i_sys_clk);
        end
    endtask

    // Count high samples per bit window, a one when above the midpoint
    task automatic measure_frames();
        int high [`FC_MOTOR_COUNT];
        wait_frame_start();
        for (int b = 0; b < 16; b++) begin
            foreach (high[i]) high[i] = 0;
            repeat (BIT_CLKS) begin
                foreach (high[i]) high[i] += motor_o[i];
                @(negedge i_sys_clk);
            end
            foreach (high[i]) meas_frame[i].raw[15-b] = (high[i] > MID_HIGH);
        end
    endtask

    task automatic wait_busy_clear();
        wb_data_t d;
        int       n;
        n = 0;
        d = 32'h1;
        while (d[0]) begin
            bus_read(CTRL_ADR, d);
            n++;
            if (n > FRAME_CLKS + `FC_DSHOT_GAP_CLKS) begin
                fail_run("DSHOT busy never cleared after the frame");
            end
        end
        check_word(d, '0, "dshot status");
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic test_reset_state();
        check_led(led_o, '1, "led_o");
        check_bit(wb_ack_o, 1'b0, "wb_ack_o");
        check_bit(wb_err_o, 1'b0, "wb_err_o");
        check_bit(usb_uart_tx_o, 1'b0, "usb_uart_tx_o");
        check_motor(motor_o, 4'b1110, "motor_o");
        usb_uart_rx_i = 1'b1;
        @(negedge i_sys_clk);
        check_motor(motor_o, 4'b1111, "motor_o");
    endtask

    task automatic test_led_and_decode();
        led_vec_t pat;
        wb_data_t d;
        pat = led_vec_t'($urandom);
        bus_write(`FC_LED_BASE, wb_data_t'(pat));
        bus_read(`FC_LED_BASE, d);
        check_word(d, wb_data_t'(pat), "led readback");
        check_led(led_o, ~pat, "led_o");
        bus_expect_err(16'h0100);
    endtask

    task automatic test_passthrough();
        wb_data_t d;
        bus_write(`FC_MSEL_BASE, 32'h4);
        bus_read(`FC_MSEL_BASE, d);
        check_word(d, 32'h4, "motor select readback");
        usb_uart_rx_i = 1'b0;
        motor_fb_i    = 4'b0100;
        @(negedge i_sys_clk);
        check_motor(motor_o, 4'b1011, "motor_o");
        check_bit(usb_uart_tx_o, 1'b1, "usb_uart_tx_o");
        usb_uart_rx_i = 1'b1;
        motor_fb_i    = 4'b1011;
        @(negedge i_sys_clk);
        check_motor(motor_o, 4'b1111, "motor_o");
        check_bit(usb_uart_tx_o, 1'b0, "usb_uart_tx_o");
    endtask

    task automatic test_dshot_frames();
        wb_data_t    d;
        logic [11:0] thr [`FC_MOTOR_COUNT];
        bus_write(`FC_MSEL_BASE, 32'h1);
        check_motor(motor_o, '0, "motor_o");
        for (int i = 0; i < `FC_MOTOR_COUNT; i++) begin
            thr[i] = 12'($urandom);
            bus_write(`FC_DSHOT_BASE + 16'(4 * i), wb_data_t'(thr[i]));
        end
        for (int i = 0; i < `FC_MOTOR_COUNT; i++) begin
            bus_read(`FC_DSHOT_BASE + 16'(4 * i), d);
            check_word(d, wb_data_t'(thr[i]), $sformatf("throttle %0d readback", i));
        end
        bus_write(CTRL_ADR, 32'h1);
        fork
            measure_frames();
            begin
                repeat (4 * BIT_CLKS) @(negedge i_sys_clk);
                bus_read(CTRL_ADR, d);
                check_word(d, 32'h1, "dshot status");
            end
        join
        for (int i = 0; i < `FC_MOTOR_COUNT; i++) begin
            check_frame(meas_frame[i], expected_frame(thr[i]), $sformatf("frame %0d", i));
        end
        wait_busy_clear();
    endtask

    // A restarted frame would show highs on the pads during the gap
    task automatic test_trigger_while_busy();
        wb_data_t d;
        busy_done = 1'b0;
        bus_write(CTRL_ADR, 32'h1);
        fork
            begin
                wait_frame_start();
                repeat (FRAME_CLKS) @(negedge i_sys_clk);
                while (!busy_done) begin
                    check_motor(motor_o, '0, "motor_o in gap");
                    @(negedge i_sys_clk);
                end
            end
            begin
                repeat (4 * BIT_CLKS) @(negedge i_sys_clk);
                bus_read(CTRL_ADR, d);
                check_word(d, 32'h1, "dshot status");
                bus_write(CTRL_ADR, 32'h1);
                wait_busy_clear();
                busy_done = 1'b1;
            end
        join
        repeat (2 * BIT_CLKS) begin
            check_motor(motor_o, '0, "motor_o after busy");
            @(negedge i_sys_clk);
        end
        bus_read(CTRL_ADR, d);
        check_word(d, '0, "dshot status");
    endtask

    initial begin
        void'($urandom(32315));
        i_sys_clk     = 1'b0;
        reset_i       = 1'b1;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_we_i       = 1'b0;
        wb_stb_i      = 1'b0;
        wb_cyc_i      = 1'b0;
        usb_uart_rx_i = 1'b0;
        motor_fb_i    = '0;
        busy_done     = 1'b0;
        repeat (10) @(negedge i_sys_clk);
        reset_i = 1'b0;
        @(negedge i_sys_clk);
        test_reset_state();
        test_led_and_decode();
        test_passthrough();
        test_dshot_frames();
        test_trigger_while_busy();
        $display("Testbench passed");
        $finish;
    end

endmodule
